// ==== Bender.yml ====
package:
  name: spi_block

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/UsiBusPkg.sv
      - src/SpiPkg.sv
      - src/SpiSlavePort.sv
      - src/SpiUsibBridge.sv
      - src/SpiCsr.sv
      - src/SpiBlock.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/SpiBlockTb.sv

// ==== sim/SpiBlockTb.sv ====
/*
 * Testbench for the SPI access block.
 * The USI master port is looped back into the CSR slave port, so SPI frames
 * from the CPU model reach the CSR block. A flash model echoes inverted MOSI.
 * Expected read data comes from a shadow register model. The run stops at
 * the first mismatch or timeout.
 */
`default_nettype none

`include "spiBlock_config.svh"

module SpiBlockTb;

	import UsiBusPkg::*;
	import SpiPkg::*;

	// sck phase length and gap between frames in sClk cycles
	localparam int SckPhase = 10;
	localparam int FrameGap = 20;
	// result kinds in the compare queue
	localparam int KindWord   = 0;
	localparam int KindDevSel = 1;
	localparam int KindPin    = 2;

	logic       sClk;
	logic       rst;
	logic       spiSck;
	logic       spiMosi;
	logic       spiCs;
	logic       spiThru;
	logic       spiMiso;
	logic       sdioDetA;
	logic       sdioDetB;
	logic       flashSck;
	logic       flashMosi;
	logic       flashCs;
	logic       flashMiso;
	logic       mUsiWe;
	logic       mUsiRe;
	usiAdrs_t   mUsiAdrs;
	usiWord_t   mUsiWd;
	usiWord_t   mUsiRd;
	logic       sUsiWe;
	logic       sUsiRe;
	usiAdrs_t   sUsiAdrs;
	usiWord_t   sUsiWd;
	usiWord_t   sUsiRd;
	logic [2:0] devSel;

	// shadow of the csr block
	usiWord_t    shScratch;
	logic [2:0]  shDevSel;
	logic [15:0] shWrCount;
	logic [1:0]  shDet;

	logic [31:0] lfsrState;
	int          weCount;
	int          reCount;

	// pending results for the compare process
	int       kindQ[$];
	usiWord_t expQ[$];
	usiWord_t gotQ[$];
	string    whatQ[$];

	SpiBlock UUT (
		.sClk(sClk),          .rst(rst),
		.spiSck(spiSck),      .spiMosi(spiMosi),
		.spiCs(spiCs),        .spiThru(spiThru),
		.spiMiso(spiMiso),
		.sdioDetA(sdioDetA),  .sdioDetB(sdioDetB),
		.flashSck(flashSck),  .flashMosi(flashMosi),
		.flashCs(flashCs),    .flashMiso(flashMiso),
		.mUsiWe(mUsiWe),      .mUsiRe(mUsiRe),
		.mUsiAdrs(mUsiAdrs),  .mUsiWd(mUsiWd),
		.mUsiRd(mUsiRd),
		.sUsiWe(sUsiWe),      .sUsiRe(sUsiRe),
		.sUsiAdrs(sUsiAdrs),  .sUsiWd(sUsiWd),
		.sUsiRd(sUsiRd),      .devSel(devSel)
	);

	// master bus looped back into the csr slave
	assign sUsiWe   = mUsiWe;
	assign sUsiRe   = mUsiRe;
	assign sUsiAdrs = mUsiAdrs;
	assign sUsiWd   = mUsiWd;
	assign mUsiRd   = sUsiRd;

	// flash model
	assign flashMiso = ~flashMosi;

	always #50 sClk = ~sClk;

	// strobe counters
	always @(posedge sClk)
	begin
		if (!rst)
		begin
			if (mUsiWe)
				weCount++;
			if (mUsiRe)
				reCount++;
		end
	end

	// --------------------------------------------------
	// error reporting and checks
	// --------------------------------------------------
	task stopOnError();
		$display("Regression failed");
		$fatal(1, "stopped at the first error");
	endtask

	task reportTimeout(input string what);
		$display("timeout: %s", what);
		stopOnError();
	endtask

	task checkUsiWord(input usiWord_t exp, input usiWord_t got, input string what);
		if (got !== exp)
		begin
			$display("ERR @%0t: %s expected %h got %h", $time, what, exp, got);
			stopOnError();
		end
	endtask

	task checkDevSel(input logic [2:0] exp, input logic [2:0] got, input string what);
		if (got !== exp)
		begin
			$display("ERR @%0t: %s expected %0d got %0d", $time, what, exp, got);
			stopOnError();
		end
	endtask

	task checkPin(input logic exp, input logic got, input string what);
		if (got !== exp)
		begin
			$display("ERR @%0t: %s expected %b got %b", $time, what, exp, got);
			stopOnError();
		end
	endtask

	task checkCount(input int exp, input int got, input string what);
		if (got != exp)
		begin
			$display("ERR @%0t: %s expected %0d got %0d", $time, what, exp, got);
			stopOnError();
		end
	endtask

	task pushCheck(input int kind, input usiWord_t exp, input usiWord_t got, input string what);
		kindQ.push_back(kind);
		expQ.push_back(exp);
		gotQ.push_back(got);
		whatQ.push_back(what);
	endtask

	// compare process drains whatever the stimulus queued
	always @(posedge sClk)
	begin : compareResults
		int       kind;
		usiWord_t exp;
		usiWord_t got;
		string    what;
		while (kindQ.size() > 0)
		begin
			kind = kindQ.pop_front();
			exp  = expQ.pop_front();
			got  = gotQ.pop_front();
			what = whatQ.pop_front();
			case (kind)
				KindWord:   checkUsiWord(exp, got, what);
				KindDevSel: checkDevSel(exp[2:0], got[2:0], what);
				default:    checkPin(exp[0], got[0], what);
			endcase
		end
	end

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	task modelWrite(input usiAdrs_t adrs, input usiWord_t dq);
		if (adrs[31:24] == `USI_BLOCK_ADRS)
		begin
			case (adrs[7:2])
				CsrScratch:
				begin
					shScratch = dq;
					shWrCount = shWrCount + 16'd1;
				end
				CsrDevSel:
				begin
					shDevSel  = dq[2:0];
					shWrCount = shWrCount + 16'd1;
				end
				default:
					shWrCount = shWrCount;
			endcase
		end
	endtask

	// zero on a foreign block or an unknown index
	function automatic usiWord_t expectedRead(input usiAdrs_t adrs);
		if (adrs[31:24] != `USI_BLOCK_ADRS)
			return '0;
		case (adrs[7:2])
			CsrId:      return `SPI_CSR_ID;
			CsrScratch: return shScratch;
			CsrStatus:  return {30'd0, shDet};
			CsrDevSel:  return {29'd0, shDevSel};
			CsrWrCount: return {16'd0, shWrCount};
			default:    return '0;
		endcase
	endfunction

	// galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task takeBits(input int n, output usiWord_t r);
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			r = {r[30:0], lfsrState[0]};
		end
	endtask

	// address built from block field, random middle bits and word index
	task makeAdrs(input logic [7:0] blk, input csrReg_e idx, output usiAdrs_t adrs);
		usiWord_t mid;
		takeBits(16, mid);
		adrs = {blk, mid[15:0], idx, 2'b00};
	endtask

	// --------------------------------------------------
	// spi cpu model
	// --------------------------------------------------
	task waitCycle();
		@(posedge sClk);
		#1;
	endtask

	task holdCycles(input int n);
		for (int i = 0; i < n; i++)
			waitCycle();
	endtask

	task waitWriteStrobe(output int lat);
		lat = 0;
		while (!mUsiWe && lat < SckPhase)
		begin
			waitCycle();
			lat++;
		end
		if (!mUsiWe)
			reportTimeout("no mUsiWe pulse after the last data bit of a write frame");
	endtask

	// mode 0 frame sent msb first
	// an nBits below the full length aborts the frame
	task spiXfer(
		input logic [7:0] op,
		input usiAdrs_t   adrs,
		input usiWord_t   dq,
		input bit         isRead,
		input int         nBits,
		input bit         expectWe,
		output usiWord_t  misoWord
	);
		logic [79:0] frame;
		int          lat;
		if (isRead)
			frame = {op, adrs, 8'h00, 32'h0};
		else
			frame = {op, adrs, dq, 8'h00};
		misoWord = '0;
		spiCs = 1'b0;
		for (int i = 0; i < nBits; i++)
		begin
			spiMosi = frame[79-i];
			holdCycles(SckPhase);
			// miso is settled by the end of the low phase
			if (i >= 48)
				misoWord = {misoWord[30:0], spiMiso};
			spiSck = 1'b1;
			if (expectWe && i == nBits - 1)
			begin
				waitWriteStrobe(lat);
				checkCount(`SPI_SYNC_STAGES + 2, lat, "sck rise to mUsiWe cycles");
				pushCheck(KindWord, adrs, mUsiAdrs, "mUsiAdrs on write strobe");
				pushCheck(KindWord, dq, mUsiWd, "mUsiWd on write strobe");
				holdCycles(SckPhase - lat);
			end
			else
				holdCycles(SckPhase);
			spiSck = 1'b0;
		end
		holdCycles(SckPhase);
		spiCs   = 1'b1;
		spiMosi = 1'b0;
		holdCycles(FrameGap);
	endtask

	task writeCsr(input usiAdrs_t adrs, input usiWord_t dq);
		usiWord_t unused;
		int       weBefore;
		weBefore = weCount;
		spiXfer(OpWrite, adrs, dq, 1'b0, 72, 1'b1, unused);
		modelWrite(adrs, dq);
		checkCount(weBefore + 1, weCount, "mUsiWe pulses per write frame");
	endtask

	task readCsr(input usiAdrs_t adrs, input string what);
		usiWord_t got;
		int       reBefore;
		reBefore = reCount;
		spiXfer(OpRead, adrs, '0, 1'b1, 80, 1'b0, got);
		pushCheck(KindWord, expectedRead(adrs), got, what);
		pushCheck(KindWord, expectedRead(adrs), sUsiRd, "sUsiRd held after read");
		pushCheck(KindWord, adrs, mUsiAdrs, "mUsiAdrs held after read");
		checkCount(reBefore + 1, reCount, "mUsiRe pulses per read frame");
	endtask

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	initial
	begin
		usiAdrs_t adrs;
		usiWord_t dq;
		usiWord_t r;
		logic [7:0] blk;
		int       weBefore;
		int       reBefore;

		sClk      = 1'b0;
		rst       = 1'b1;
		spiSck    = 1'b0;
		spiMosi   = 1'b0;
		spiCs     = 1'b1;
		spiThru   = 1'b0;
		sdioDetA  = 1'b0;
		sdioDetB  = 1'b0;
		shScratch = '0;
		shDevSel  = 3'd0;
		shWrCount = 16'd0;
		shDet     = 2'b00;
		lfsrState = 32'h27cf9458;
		weCount   = 0;
		reCount   = 0;

		holdCycles(10);
		rst = 1'b0;
		waitCycle();

		// idle levels after reset
		pushCheck(KindPin, usiWord_t'(1'b0), usiWord_t'(mUsiWe), "mUsiWe after reset");
		pushCheck(KindPin, usiWord_t'(1'b0), usiWord_t'(mUsiRe), "mUsiRe after reset");
		pushCheck(KindPin, usiWord_t'(1'b1), usiWord_t'(flashCs), "flashCs after reset");
		pushCheck(KindPin, usiWord_t'(1'b0), usiWord_t'(flashSck), "flashSck after reset");
		pushCheck(KindPin, usiWord_t'(1'b0), usiWord_t'(flashMosi), "flashMosi after reset");
		pushCheck(KindPin, usiWord_t'(1'b0), usiWord_t'(spiMiso), "spiMiso after reset");
		makeAdrs(`USI_BLOCK_ADRS, CsrId, adrs);
		readCsr(adrs, "ID register");
		makeAdrs(`USI_BLOCK_ADRS, CsrWrCount, adrs);
		readCsr(adrs, "write count after reset");

		// scratch and devSel round trips
		for (int n = 0; n < 4; n++)
		begin
			takeBits(32, dq);
			makeAdrs(`USI_BLOCK_ADRS, CsrScratch, adrs);
			writeCsr(adrs, dq);
			takeBits(32, dq);
			makeAdrs(`USI_BLOCK_ADRS, CsrDevSel, adrs);
			writeCsr(adrs, dq);
			makeAdrs(`USI_BLOCK_ADRS, CsrScratch, adrs);
			readCsr(adrs, "scratch readback");
			makeAdrs(`USI_BLOCK_ADRS, CsrDevSel, adrs);
			readCsr(adrs, "devSel readback");
			pushCheck(KindDevSel, {29'd0, shDevSel}, {29'd0, devSel}, "devSel port");
			makeAdrs(`USI_BLOCK_ADRS, CsrWrCount, adrs);
			readCsr(adrs, "write count");
		end

		// card detect in all four pin combinations
		for (int c = 0; c < 4; c++)
		begin
			sdioDetA = c[0];
			sdioDetB = c[1];
			shDet    = c[1:0];
			makeAdrs(`USI_BLOCK_ADRS, CsrStatus, adrs);
			readCsr(adrs, "sdio detect status");
		end

		// foreign block write reaches the bus but no register
		takeBits(8, r);
		blk = r[7:0];
		if (blk == `USI_BLOCK_ADRS)
			blk = ~blk;
		takeBits(32, dq);
		makeAdrs(blk, CsrScratch, adrs);
		writeCsr(adrs, dq);
		readCsr(adrs, "foreign block read");

		// unknown opcode and aborted frame cause no bus cycle at all
		weBefore = weCount;
		reBefore = reCount;
		takeBits(32, dq);
		makeAdrs(`USI_BLOCK_ADRS, CsrScratch, adrs);
		spiXfer(8'h5a, adrs, dq, 1'b0, 72, 1'b0, r);
		pushCheck(KindWord, '0, r, "miso during unknown opcode frame");
		spiXfer(OpWrite, adrs, dq, 1'b0, 56, 1'b0, r);
		checkCount(weBefore, weCount, "mUsiWe pulses after ignored frames");
		checkCount(reBefore, reCount, "mUsiRe pulses after ignored frames");
		readCsr(adrs, "scratch after ignored frames");
		makeAdrs(`USI_BLOCK_ADRS, CsrWrCount, adrs);
		readCsr(adrs, "write count after ignored frames");

		// --------------------------------------------------
		// thru mode hands the pins to the flash model
		// --------------------------------------------------
		weBefore = weCount;
		reBefore = reCount;
		spiThru = 1'b1;
		for (int n = 0; n < 16; n++)
		begin
			takeBits(3, r);
			spiSck  = r[0];
			spiMosi = r[1];
			spiCs   = r[2];
			waitCycle();
			pushCheck(KindPin, usiWord_t'(r[0]), usiWord_t'(flashSck), "flashSck in thru");
			pushCheck(KindPin, usiWord_t'(r[1]), usiWord_t'(flashMosi), "flashMosi in thru");
			pushCheck(KindPin, usiWord_t'(r[2]), usiWord_t'(flashCs), "flashCs in thru");
			pushCheck(KindPin, usiWord_t'(~r[1]), usiWord_t'(spiMiso), "spiMiso in thru");
		end
		spiSck  = 1'b0;
		spiMosi = 1'b0;
		spiCs   = 1'b1;
		holdCycles(FrameGap);
		// a complete scratch write frame goes to the flash only
		takeBits(32, dq);
		makeAdrs(`USI_BLOCK_ADRS, CsrScratch, adrs);
		spiXfer(OpWrite, adrs, dq, 1'b0, 72, 1'b0, r);
		spiThru = 1'b0;
		holdCycles(FrameGap);
		checkCount(weBefore, weCount, "mUsiWe pulses in thru mode");
		checkCount(reBefore, reCount, "mUsiRe pulses in thru mode");
		readCsr(adrs, "scratch after thru mode");

		// let the compare process catch up
		for (int i = 0; i < 4 && kindQ.size() > 0; i++)
			waitCycle();
		if (kindQ.size() > 0)
			reportTimeout("compare queue did not drain at the end of the run");

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/SpiBlock.sv ====
/*
 * SPI access block, top level.
 * An external CPU reaches the USI bus through the slave port and the bridge,
 * and the CSR block sits on the same bus as a slave. With spiThru high the
 * SPI pins go straight to the serial flash and the slave port stays idle.
 */
`default_nettype none

module SpiBlock (
	input  wire                      sClk,
	input  wire                      rst,
	// cpu side spi
	input  wire                      spiSck,
	input  wire                      spiMosi,
	input  wire                      spiCs,
	input  wire                      spiThru,
	output logic                     spiMiso,
	// sdio card detect
	input  wire                      sdioDetA,
	input  wire                      sdioDetB,
	// serial flash
	output logic                     flashSck,
	output logic                     flashMosi,
	output logic                     flashCs,
	input  wire                      flashMiso,
	// usi bus master
	output logic                     mUsiWe,
	output logic                     mUsiRe,
	output UsiBusPkg::usiAdrs_t      mUsiAdrs,
	output UsiBusPkg::usiWord_t      mUsiWd,
	input  wire UsiBusPkg::usiWord_t mUsiRd,
	// usi bus slave
	input  wire                      sUsiWe,
	input  wire                      sUsiRe,
	input  wire UsiBusPkg::usiAdrs_t sUsiAdrs,
	input  wire UsiBusPkg::usiWord_t sUsiWd,
	output UsiBusPkg::usiWord_t      sUsiRd,
	output logic [2:0]               devSel
);

	import UsiBusPkg::*;

	// slave port to bridge
	logic     portMiso;
	logic     decWe;
	logic     decRe;
	usiAdrs_t decAdrs;
	usiWord_t decDq;
	usiWord_t rdData;

	// --------------------------------------------------
	// csr block on the slave bus
	// --------------------------------------------------
	SpiCsr SpiCsr (
		.sClk(sClk),          .rst(rst),
		.sUsiWe(sUsiWe),      .sUsiRe(sUsiRe),
		.sUsiAdrs(sUsiAdrs),  .sUsiWd(sUsiWd),
		.sdioDetA(sdioDetA),  .sdioDetB(sdioDetB),
		.sUsiRd(sUsiRd),      .devSel(devSel)
	);

	// --------------------------------------------------
	// spi frame decode and bus master
	// --------------------------------------------------
	SpiSlavePort SpiSlavePort (
		.sClk(sClk),          .rst(rst),
		.spiSck(spiSck),      .spiMosi(spiMosi),
		.spiCs(spiCs),        .spiThru(spiThru),
		.rdData(rdData),      .spiMiso(portMiso),
		.decWe(decWe),        .decRe(decRe),
		.decAdrs(decAdrs),    .decDq(decDq)
	);

	SpiUsibBridge SpiUsibBridge (
		.sClk(sClk),          .rst(rst),
		.decWe(decWe),        .decRe(decRe),
		.decAdrs(decAdrs),    .decDq(decDq),
		.mUsiRd(mUsiRd),
		.mUsiWe(mUsiWe),      .mUsiRe(mUsiRe),
		.mUsiAdrs(mUsiAdrs),  .mUsiWd(mUsiWd),
		.rdData(rdData)
	);

	// --------------------------------------------------
	// flash thru mux
	// --------------------------------------------------
	// flash parked with cs high and lines low unless thru is on
	assign flashSck  = spiThru & spiSck;
	assign flashMosi = spiThru & spiMosi;
	assign flashCs   = ~spiThru | spiCs;
	// cpu sees the flash in thru mode, the slave port otherwise
	assign spiMiso   = spiThru ? flashMiso : portMiso;

endmodule

`default_nettype wire

// ==== src/SpiCsr.sv ====
/*
 * Control and status registers of the SPI block, a USI bus slave.
 * Answers only when address bits 31..24 match the block map value.
 * Read data comes two cycles after sUsiRe and is zero on a miss, so
 * several slave outputs can be ORed onto one read bus.
 */
`default_nettype none

`include "spiBlock_config.svh"

module SpiCsr (
	input  wire                      sClk,
	input  wire                      rst,
	input  wire                      sUsiWe,
	input  wire                      sUsiRe,
	input  wire UsiBusPkg::usiAdrs_t sUsiAdrs,
	input  wire UsiBusPkg::usiWord_t sUsiWd,
	input  wire                      sdioDetA,
	input  wire                      sdioDetB,
	output UsiBusPkg::usiWord_t      sUsiRd,
	output logic [2:0]               devSel
);

	import UsiBusPkg::*;

	// {detB, detA} per stage
	logic [1:0] detSync [0:`SPI_SYNC_STAGES-1];

	logic                               blkHit;
	logic [USI_IDX_MSB-USI_IDX_LSB:0]   regIdx;
	usiWord_t                           scratch;
	logic [2:0]                         devSelReg;
	logic [15:0]                        wrCount;

	// read pipe
	logic                               rdPend;
	logic                               rdHit;
	logic [USI_IDX_MSB-USI_IDX_LSB:0]   rdIdx;
	usiWord_t                           rdMux;

	// --------------------------------------------------
	// sdio card detect sync
	// --------------------------------------------------
	always_ff @(posedge sClk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `SPI_SYNC_STAGES; i++)
				detSync[i] <= 2'b00;
		end
		else
		begin
			detSync[0] <= {sdioDetB, sdioDetA};
			for (int i = 1; i < `SPI_SYNC_STAGES; i++)
				detSync[i] <= detSync[i-1];
		end
	end

	// address decode
	assign blkHit = (sUsiAdrs[USI_BLK_MSB:USI_BLK_LSB] == `USI_BLOCK_ADRS);
	assign regIdx = sUsiAdrs[USI_IDX_MSB:USI_IDX_LSB];

	// --------------------------------------------------
	// write side
	// --------------------------------------------------
	always_ff @(posedge sClk)
	begin
		if (rst)
		begin
			scratch   <= '0;
			devSelReg <= 3'd0;
			wrCount   <= 16'd0;
		end
		else if (sUsiWe && blkHit)
		begin
			// id, status and count are read only
			case (regIdx)
				CsrScratch:
				begin
					scratch <= sUsiWd;
					wrCount <= wrCount + 1'b1;
				end
				CsrDevSel:
				begin
					devSelReg <= sUsiWd[2:0];
					wrCount   <= wrCount + 1'b1;
				end
				default:
					wrCount <= wrCount;
			endcase
		end
	end

	// --------------------------------------------------
	// read side
	// --------------------------------------------------
	// cycle 1, latch the selection
	always_ff @(posedge sClk)
	begin
		if (rst)
			rdPend <= 1'b0;
		else
			rdPend <= sUsiRe;
	end

	always_ff @(posedge sClk)
	begin
		if (sUsiRe)
		begin
			rdHit <= blkHit;
			rdIdx <= regIdx;
		end
	end

	// unknown index or foreign block reads as zero
	always_comb
	begin
		rdMux = '0;
		if (rdHit)
		begin
			case (rdIdx)
				CsrId:      rdMux = `SPI_CSR_ID;
				CsrScratch: rdMux = scratch;
				CsrStatus:  rdMux = {30'd0, detSync[`SPI_SYNC_STAGES-1]};
				CsrDevSel:  rdMux = {29'd0, devSelReg};
				CsrWrCount: rdMux = {16'd0, wrCount};
				default:    rdMux = '0;
			endcase
		end
	end

	// cycle 2, word on the bus until the next read
	always_ff @(posedge sClk)
	begin
		if (rst)
			sUsiRd <= '0;
		else if (rdPend)
			sUsiRd <= rdMux;
	end

	assign devSel = devSelReg;

endmodule

`default_nettype wire

// ==== src/SpiPkg.sv ====
/*
 * Frame level definitions for the SPI slave port.
 * Opcodes, the frame FSM states and the field lengths of a frame.
 * Import it inside the body of a module that decodes SPI frames.
 */
`default_nettype none

`include "spiBlock_config.svh"

package SpiPkg;

	// field lengths in sck periods
	localparam int SPI_OP_BITS    = 8;
	localparam int SPI_DUMMY_BITS = 8;
	localparam int SPI_WORD_BITS  = `USI_BUS_WIDTH;

	// counts bits inside one field, widest field is a word
	typedef logic [$clog2(SPI_WORD_BITS)-1:0] spiBitCnt_t;

	// frame opcodes
	typedef enum logic [SPI_OP_BITS-1:0] {
		OpWrite = 8'h02,
		OpRead  = 8'h03
	} spiOp_e;

	// frame FSM
	typedef enum logic [2:0] {
		StIdle,
		StOpcode,
		StAdrs,
		StDummy,
		StData,
		StSkip
	} spiState_e;

endpackage

`default_nettype wire

// ==== src/SpiSlavePort.sv ====
/*
 * SPI mode 0 slave for the external CPU, oversampled on sClk.
 * Decodes write and read frames into one-cycle decWe / decRe strobes
 * with decAdrs and decDq, and shifts rdData out on MISO for reads.
 * Held idle while spiThru hands the pins to the flash.
 */
`default_nettype none

`include "spiBlock_config.svh"

module SpiSlavePort (
	input  wire                      sClk,
	input  wire                      rst,
	input  wire                      spiSck,
	input  wire                      spiMosi,
	input  wire                      spiCs,
	input  wire                      spiThru,
	input  wire UsiBusPkg::usiWord_t rdData,
	output logic                     spiMiso,
	output logic                     decWe,
	output logic                     decRe,
	output UsiBusPkg::usiAdrs_t      decAdrs,
	output UsiBusPkg::usiWord_t      decDq
);

	import UsiBusPkg::*;
	import SpiPkg::*;

	// {sck, mosi, cs} per stage
	logic [2:0] pinSync [0:`SPI_SYNC_STAGES-1];
	logic       sckNow;
	logic       mosiNow;
	logic       csNow;
	logic       sckPrev;
	logic       csPrev;
	logic       sckRise;
	logic       sckFall;
	logic       csFall;

	spiState_e  state;
	spiOp_e     opReg;
	spiBitCnt_t bitCnt;
	logic       phaseEnd;
	logic       misoEn;
	usiWord_t   shiftIn;
	usiWord_t   wordIn;
	usiWord_t   shiftOut;
	usiAdrs_t   adrsReg;
	usiWord_t   dqReg;

	// --------------------------------------------------
	// pin sync and edge detect
	// --------------------------------------------------
	// idle levels: sck low, cs high
	always_ff @(posedge sClk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `SPI_SYNC_STAGES; i++)
				pinSync[i] <= 3'b001;
			sckPrev <= 1'b0;
			csPrev  <= 1'b1;
		end
		else
		begin
			pinSync[0] <= {spiSck, spiMosi, spiCs};
			for (int i = 1; i < `SPI_SYNC_STAGES; i++)
				pinSync[i] <= pinSync[i-1];
			sckPrev <= sckNow;
			csPrev  <= csNow;
		end
	end

	assign sckNow  = pinSync[`SPI_SYNC_STAGES-1][2];
	assign mosiNow = pinSync[`SPI_SYNC_STAGES-1][1];
	assign csNow   = pinSync[`SPI_SYNC_STAGES-1][0];
	assign sckRise = sckNow & ~sckPrev;
	assign sckFall = ~sckNow & sckPrev;
	assign csFall  = csPrev & ~csNow;

	// word as it stands after the bit on this rising edge
	assign wordIn = {shiftIn[SPI_WORD_BITS-2:0], mosiNow};

	// last bit of the current field
	always_comb
	begin
		case (state)
			StOpcode: phaseEnd = (bitCnt == spiBitCnt_t'(SPI_OP_BITS - 1));
			StAdrs:   phaseEnd = (bitCnt == spiBitCnt_t'(SPI_WORD_BITS - 1));
			StDummy:  phaseEnd = (bitCnt == spiBitCnt_t'(SPI_DUMMY_BITS - 1));
			StData:   phaseEnd = (bitCnt == spiBitCnt_t'(SPI_WORD_BITS - 1));
			default:  phaseEnd = 1'b0;
		endcase
	end

	// --------------------------------------------------
	// frame FSM
	// --------------------------------------------------
	always_ff @(posedge sClk)
	begin
		if (rst)
		begin
			state  <= StIdle;
			opReg  <= OpWrite;
			bitCnt <= '0;
			misoEn <= 1'b0;
			decWe  <= 1'b0;
			decRe  <= 1'b0;
		end
		else
		begin
			// strobes last one cycle
			decWe <= 1'b0;
			decRe <= 1'b0;
			if (spiThru || csNow)
			begin
				// cs high or thru mode, any open frame is dropped
				state  <= StIdle;
				bitCnt <= '0;
				misoEn <= 1'b0;
			end
			else if (state == StIdle)
			begin
				// new frame only on a real cs falling edge
				if (csFall)
				begin
					state  <= StOpcode;
					bitCnt <= '0;
				end
			end
			else if (sckRise)
			begin
				bitCnt <= phaseEnd ? '0 : bitCnt + 1'b1;
				case (state)
					StOpcode:
						if (phaseEnd)
						begin
							if (wordIn[SPI_OP_BITS-1:0] == OpWrite ||
								wordIn[SPI_OP_BITS-1:0] == OpRead)
							begin
								opReg <= spiOp_e'(wordIn[SPI_OP_BITS-1:0]);
								state <= StAdrs;
							end
							else
								state <= StSkip;
						end
					StAdrs:
						if (phaseEnd)
						begin
							adrsReg <= wordIn;
							// read is issued now so the dummy byte hides the latency
							if (opReg == OpRead)
							begin
								decRe <= 1'b1;
								state <= StDummy;
							end
							else
								state <= StData;
						end
					StDummy:
						if (phaseEnd)
						begin
							state  <= StData;
							misoEn <= 1'b1;
						end
					StData:
						if (phaseEnd)
						begin
							if (opReg == OpWrite)
							begin
								dqReg <= wordIn;
								decWe <= 1'b1;
							end
							state  <= StSkip;
							misoEn <= 1'b0;
						end
					default:
						// StSkip waits for cs high
						state <= state;
				endcase
			end
		end
	end

	// --------------------------------------------------
	// shift registers
	// --------------------------------------------------
	always_ff @(posedge sClk)
	begin
		if (sckRise)
			shiftIn <= wordIn;
	end

	// msb is out before the first data rise, then moves on each later fall
	always_ff @(posedge sClk)
	begin
		if (state == StDummy && sckRise && phaseEnd)
			shiftOut <= rdData;
		else if (state == StData && sckFall && bitCnt != '0)
			shiftOut <= {shiftOut[SPI_WORD_BITS-2:0], 1'b0};
	end

	assign spiMiso = misoEn & shiftOut[SPI_WORD_BITS-1];
	assign decAdrs = adrsReg;
	assign decDq   = dqReg;

endmodule

`default_nettype wire

// ==== src/SpiUsibBridge.sv ====
/*
 * Bridge from decoded SPI requests to the USI bus as master.
 * Each decWe / decRe becomes a one-cycle mUsiWe / mUsiRe one cycle later.
 * Read data is taken from mUsiRd after the fixed bus read latency and
 * held on rdData for the slave port until the next read.
 */
`default_nettype none

`include "spiBlock_config.svh"

module SpiUsibBridge (
	input  wire                      sClk,
	input  wire                      rst,
	input  wire                      decWe,
	input  wire                      decRe,
	input  wire UsiBusPkg::usiAdrs_t decAdrs,
	input  wire UsiBusPkg::usiWord_t decDq,
	input  wire UsiBusPkg::usiWord_t mUsiRd,
	output logic                     mUsiWe,
	output logic                     mUsiRe,
	output UsiBusPkg::usiAdrs_t      mUsiAdrs,
	output UsiBusPkg::usiWord_t      mUsiWd,
	output UsiBusPkg::usiWord_t      rdData
);

	localparam int LAT_W = $clog2(`USI_RD_LATENCY + 1);

	// cycles left until read data is valid, 0 when no read is open
	logic [LAT_W-1:0] latCnt;
	logic             rdCapture;

	// --------------------------------------------------
	// master strobes
	// --------------------------------------------------
	always_ff @(posedge sClk)
	begin
		if (rst)
		begin
			mUsiWe <= 1'b0;
			mUsiRe <= 1'b0;
		end
		else
		begin
			mUsiWe <= decWe;
			mUsiRe <= decRe;
		end
	end

	// address and data stay until the next request
	always_ff @(posedge sClk)
	begin
		if (decWe || decRe)
			mUsiAdrs <= decAdrs;
		if (decWe)
			mUsiWd <= decDq;
	end

	// --------------------------------------------------
	// read return
	// --------------------------------------------------
	always_ff @(posedge sClk)
	begin
		if (rst)
			latCnt <= '0;
		else if (mUsiRe)
			latCnt <= LAT_W'(`USI_RD_LATENCY);
		else if (latCnt != '0)
			latCnt <= latCnt - 1'b1;
	end

	// last count is the cycle the slave has its word on the bus
	assign rdCapture = (latCnt == LAT_W'(1));

	always_ff @(posedge sClk)
	begin
		if (rdCapture)
			rdData <= mUsiRd;
	end

endmodule

`default_nettype wire

// ==== src/UsiBusPkg.sv ====
/*
 * Types shared by everything that talks on the USI register bus.
 * Holds the word and address types, the address field positions and the
 * register index of the CSR block. Import it inside a module body.
 */
`default_nettype none

`include "spiBlock_config.svh"

package UsiBusPkg;

	// one bus word
	typedef logic [`USI_BUS_WIDTH-1:0] usiWord_t;

	// one bus address
	typedef logic [`USI_BUS_WIDTH-1:0] usiAdrs_t;

	// --------------------------------------------------
	// address fields
	// --------------------------------------------------
	// block select field
	localparam int USI_BLK_MSB = 31;
	localparam int USI_BLK_LSB = 24;
	// register word index, byte offset dropped
	localparam int USI_IDX_MSB = 7;
	localparam int USI_IDX_LSB = 2;

	// csr register index
	typedef enum logic [USI_IDX_MSB-USI_IDX_LSB:0] {
		CsrId      = 6'd0,
		CsrScratch = 6'd1,
		CsrStatus  = 6'd2,
		CsrDevSel  = 6'd3,
		CsrWrCount = 6'd4
	} csrReg_e;

endpackage

`default_nettype wire

// ==== src/spiBlock_config.svh ====
/*
 * Build-time constants for the SPI access block.
 * Include this header wherever a bus width, the block map value, the read
 * latency, the ID word or the SCK sampling rules are needed.
 */
`ifndef SPI_BLOCK_CONFIG_SVH
`define SPI_BLOCK_CONFIG_SVH

// --------------------------------------------------
// USI bus
// --------------------------------------------------
// data and address width
`define USI_BUS_WIDTH 32
// map value in address bits 31..24
`define USI_BLOCK_ADRS 8'h03
// read strobe to valid read data, in sClk cycles
`define USI_RD_LATENCY 2

// --------------------------------------------------
// SPI port and CSR
// --------------------------------------------------
// ID register value, ascii "SPI1"
`define SPI_CSR_ID 32'h5350_4931
// synchronizer depth for sck, mosi, cs and sdio detect
`define SPI_SYNC_STAGES 2
// shortest sck high or low phase, in sClk cycles
`define SPI_SCK_MIN_PHASE 8

`endif

// ==== tb.f ====
+incdir+src
src/UsiBusPkg.sv
src/SpiPkg.sv
src/SpiSlavePort.sv
src/SpiUsibBridge.sv
src/SpiCsr.sv
src/SpiBlock.sv
sim/SpiBlockTb.sv
